// ==== crt_pkg.sv ====
package crt_pkg;

  // ******************************
  // I/O port codes
  // ******************************
  typedef enum logic [2:0] {
    PORT_CRTC_IDX  = 3'd0,
    PORT_CRTC_DATA = 3'd1,
    PORT_SEQ_IDX   = 3'd2,
    PORT_SEQ_DATA  = 3'd3,
    PORT_ATTR      = 3'd4,
    PORT_STATUS    = 3'd5
  } crt_port_t;

  // crtc register indexes that are kept
  localparam logic [7:0] CR_H_TOTAL       = 8'h00;
  localparam logic [7:0] CR_H_DISP_END    = 8'h01;
  localparam logic [7:0] CR_H_BLANK_START = 8'h02;
  localparam logic [7:0] CR_H_BLANK_END   = 8'h03;
  localparam logic [7:0] CR_H_SYNC_START  = 8'h04;
  localparam logic [7:0] CR_H_SYNC_END    = 8'h05;
  localparam logic [7:0] CR_V_TOTAL       = 8'h06;
  localparam logic [7:0] CR_V_SYNC_START  = 8'h10;
  localparam logic [7:0] CR_V_SYNC_END    = 8'h11;  // cr11
  localparam logic [7:0] CR_V_DISP_END    = 8'h12;
  localparam logic [7:0] CR_V_BLANK_START = 8'h15;
  localparam logic [7:0] CR_V_BLANK_END   = 8'h16;

  localparam logic [7:0] SR_CLK_MODE      = 8'h01;  // sr01

  typedef struct packed {
    logic [7:0] h_total;
    logic [7:0] h_disp_end;
    logic [7:0] h_blank_start;
    logic [7:0] h_blank_end;
    logic [7:0] h_sync_start;
    logic [7:0] h_sync_end;
    logic [7:0] v_total;
    logic [7:0] v_disp_end;
    logic [7:0] v_blank_start;
    logic [7:0] v_blank_end;
    logic [7:0] v_sync_start;
    logic [7:0] cr11;           // [5] int enable_n, [4] int clear_n, [3:0] vsync end
  } crt_regs_t;

  typedef struct packed {
    logic [7:0] sr01;           // [5] screen off, [0] 8 dot chars
  } seq_regs_t;

  typedef struct packed {
    logic [1:0] rsvd;
    logic       pas;            // palette address source
    logic [4:0] index;
  } attr_index_t;

  typedef union packed {
    attr_index_t idx;
    logic [7:0]  data;
  } attr_word_u;

  typedef struct packed {
    logic hde;
    logic ahde;
    logic vde;
    logic hblank;
    logic vblank;
    logic hsync;
    logic vsync;
    logic cclk_en;
    logic dclk_en;
    logic line_end;
  } crt_timing_t;

endpackage

// ==== crt_reg_decode.sv ====
module crt_reg_decode (
  input  logic               t_crt_clk,
  input  logic               h_reset_n,
  input  logic               io_wr,
  input  logic               io_rd,
  input  crt_pkg::crt_port_t io_port,
  input  logic [7:0]         io_wdata,
  output crt_pkg::crt_regs_t crt_regs,
  output crt_pkg::seq_regs_t seq_regs,
  output logic               attr_pas
);
  import crt_pkg::*;

  logic [7:0] crtc_idx;
  logic [7:0] seq_idx;
  logic       attr_ff;        // low in index state, high in data state
  attr_word_u attr_word;
  logic       crtc_idx_wr;
  logic       crtc_data_wr;
  logic       seq_idx_wr;
  logic       seq_data_wr;
  logic       attr_wr;
  logic       status_rd;

  // ******************************
  // strobe decode
  // ******************************
  assign crtc_idx_wr  = io_wr & (io_port == PORT_CRTC_IDX);
  assign crtc_data_wr = io_wr & (io_port == PORT_CRTC_DATA);
  assign seq_idx_wr   = io_wr & (io_port == PORT_SEQ_IDX);
  assign seq_data_wr  = io_wr & (io_port == PORT_SEQ_DATA);
  assign attr_wr      = io_wr & (io_port == PORT_ATTR);
  assign status_rd    = io_rd & (io_port == PORT_STATUS);

  assign attr_word.data = io_wdata;

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      crtc_idx <= 8'h00;
      seq_idx  <= 8'h00;
    end else begin
      if (crtc_idx_wr) crtc_idx <= io_wdata;
      if (seq_idx_wr)  seq_idx  <= io_wdata;
    end
  end

  // ******************************
  // register bank
  // ******************************
  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      crt_regs <= '0;
    end else if (crtc_data_wr) begin
      case (crtc_idx)
        CR_H_TOTAL:       crt_regs.h_total       <= io_wdata;
        CR_H_DISP_END:    crt_regs.h_disp_end    <= io_wdata;
        CR_H_BLANK_START: crt_regs.h_blank_start <= io_wdata;
        CR_H_BLANK_END:   crt_regs.h_blank_end   <= io_wdata;
        CR_H_SYNC_START:  crt_regs.h_sync_start  <= io_wdata;
        CR_H_SYNC_END:    crt_regs.h_sync_end    <= io_wdata;
        CR_V_TOTAL:       crt_regs.v_total       <= io_wdata;
        CR_V_SYNC_START:  crt_regs.v_sync_start  <= io_wdata;
        CR_V_SYNC_END:    crt_regs.cr11          <= io_wdata;
        CR_V_DISP_END:    crt_regs.v_disp_end    <= io_wdata;
        CR_V_BLANK_START: crt_regs.v_blank_start <= io_wdata;
        CR_V_BLANK_END:   crt_regs.v_blank_end   <= io_wdata;
        default: ;                               // index not kept
      endcase
    end
  end

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      seq_regs <= '0;
    end else if (seq_data_wr && (seq_idx == SR_CLK_MODE)) begin
      seq_regs.sr01 <= io_wdata;
    end
  end

  // ******************************
  // attribute flip-flop
  // ******************************
  // the status read wins over a write in the same clock
  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      attr_ff <= 1'b0;
    end else if (status_rd) begin
      attr_ff <= 1'b0;
    end else if (attr_wr) begin
      attr_ff <= ~attr_ff;
    end
  end

  // palette and mode data go nowhere in this frame, so a data write only toggles
  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      attr_pas <= 1'b0;
    end else if (attr_wr && !attr_ff && !status_rd) begin
      attr_pas <= attr_word.idx.pas;    // index state
    end
  end

endmodule

// ==== crt_timing_gen.sv ====
module crt_timing_gen #(
  parameter int DOTS_MAX = 9
) (
  input  logic                 t_crt_clk,
  input  logic                 h_reset_n,
  input  crt_pkg::crt_regs_t   crt_regs,
  input  logic                 sr01_b0,
  output crt_pkg::crt_timing_t timing
);
  import crt_pkg::*;

  localparam int DW = $clog2(DOTS_MAX);

  logic [DW-1:0] dot_cnt;
  logic [DW-1:0] dot_last;
  logic          cclk_en;
  logic [7:0]    h_cnt;
  logic [7:0]    h_next;
  logic          h_last;
  logic [7:0]    v_cnt;
  logic          v_last;
  logic          line_end;
  logic [7:0]    v_sync_end;

  // inclusive compare window, wraps through zero when first > last
  function automatic logic in_range(
    input logic [7:0] cnt,
    input logic [7:0] first,
    input logic [7:0] last
  );
    logic hit;
    if (first <= last) begin
      hit = (cnt >= first) && (cnt <= last);
    end else begin
      hit = (cnt >= first) || (cnt <= last);
    end
    return hit;
  endfunction

  // ******************************
  // dot to character divider
  // ******************************
  assign dot_last = sr01_b0 ? DW'(7) : DW'(DOTS_MAX - 1);
  assign cclk_en  = (dot_cnt >= dot_last);   // >= covers a 9 to 8 switch mid char

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      dot_cnt <= '0;
    end else if (cclk_en) begin
      dot_cnt <= '0;
    end else begin
      dot_cnt <= dot_cnt + DW'(1);
    end
  end

  // ******************************
  // horizontal and vertical counts
  // ******************************
  assign h_last   = (h_cnt >= crt_regs.h_total);
  assign h_next   = h_last ? 8'd0 : h_cnt + 8'd1;
  assign line_end = cclk_en & h_last;

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      h_cnt <= 8'd0;
    end else if (cclk_en) begin
      h_cnt <= h_next;
    end
  end

  assign v_last = (v_cnt >= crt_regs.v_total);

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      v_cnt <= 8'd0;
    end else if (line_end) begin
      v_cnt <= v_last ? 8'd0 : v_cnt + 8'd1;
    end
  end

  // only the low nibble of the sync end is programmed
  always_comb begin
    v_sync_end = {crt_regs.v_sync_start[7:4], crt_regs.cr11[3:0]};
    if (crt_regs.cr11[3:0] < crt_regs.v_sync_start[3:0]) begin
      v_sync_end = v_sync_end + 8'd16;
    end
  end

  // ******************************
  // enables, blanking and sync
  // ******************************
  always_comb begin
    timing.hde      = (h_cnt <= crt_regs.h_disp_end);
    timing.ahde     = (h_next <= crt_regs.h_disp_end);   // one char ahead
    timing.vde      = (v_cnt <= crt_regs.v_disp_end);
    timing.hblank   = in_range(h_cnt, crt_regs.h_blank_start, crt_regs.h_blank_end);
    timing.vblank   = in_range(v_cnt, crt_regs.v_blank_start, crt_regs.v_blank_end);
    timing.hsync    = in_range(h_cnt, crt_regs.h_sync_start, crt_regs.h_sync_end);
    timing.vsync    = in_range(v_cnt, crt_regs.v_sync_start, v_sync_end);
    timing.cclk_en  = cclk_en;
    timing.dclk_en  = 1'b1;                              // dot clock is the core clock
    timing.line_end = line_end;
  end

endmodule

// ==== crt_op_stage.sv ====
module crt_op_stage (
  input  logic                 t_crt_clk,
  input  logic                 h_reset_n,
  input  crt_pkg::crt_timing_t timing,
  input  logic [7:0]           cr11,
  input  logic                 sr01_b5,
  input  logic                 attr_pas,
  input  logic                 vga_en,
  output logic                 crt_int,
  output logic                 attr_de,
  output logic                 cblank_n,
  output logic                 ade,
  output logic                 screen_off,
  output logic                 dis_en_sta
);
  import crt_pkg::*;

  logic [2:0] hde_d_cc;
  logic [1:0] vde_sync;
  logic [1:0] pas_sync;
  logic [1:0] off_sync;        // resets to ones, screen off after reset
  logic [3:0] blank_d_cc;
  logic       gated_hde;
  logic [2:0] attr_de_d;
  logic [4:0] blank_d_dc;
  logic       blank_ff;
  logic       intrpt_ff;
  logic       ade_ff;
  logic       comp_blank;
  logic       int_blank;

  assign comp_blank = timing.hblank | timing.vblank;

  // ******************************
  // character clock stages
  // ******************************
  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      hde_d_cc   <= 3'b000;
      vde_sync   <= 2'b00;
      pas_sync   <= 2'b00;
      off_sync   <= 2'b11;
      blank_d_cc <= 4'b0000;
    end else if (timing.cclk_en) begin
      hde_d_cc   <= {hde_d_cc[1:0], timing.hde};
      vde_sync   <= {vde_sync[0], timing.vde};
      pas_sync   <= {pas_sync[0], attr_pas};
      off_sync   <= {off_sync[0], sr01_b5 | ~vga_en};
      blank_d_cc <= {blank_d_cc[2:0], comp_blank};
    end
  end

  assign screen_off = off_sync[1];
  assign dis_en_sta = ~(hde_d_cc[2] & vde_sync[1]);   // low inside the display area
  assign int_blank  = off_sync[1] | blank_d_cc[3];

  // ******************************
  // dot clock stages
  // ******************************
  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      gated_hde  <= 1'b0;
      attr_de_d  <= 3'b000;
      blank_d_dc <= 5'b00000;
    end else if (timing.dclk_en) begin
      gated_hde  <= pas_sync[1] & hde_d_cc[2];
      attr_de_d  <= {attr_de_d[1:0], gated_hde & vde_sync[1]};
      blank_d_dc <= {blank_d_dc[3:0], int_blank};
    end
  end

  assign attr_de = attr_de_d[2];

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) blank_ff <= 1'b0;
    else            blank_ff <= blank_d_dc[4];
  end

  assign cblank_n = ~blank_ff;

  // vertical retrace interrupt, held until cr11 bit 4 goes low
  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      intrpt_ff <= 1'b0;
    end else if (timing.cclk_en) begin
      intrpt_ff <= (intrpt_ff | ~timing.vde) & cr11[4];
    end
  end

  assign crt_int = intrpt_ff & ~cr11[5];

  always_ff @(posedge t_crt_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      ade_ff <= 1'b0;
    end else if (timing.line_end) begin
      ade_ff <= timing.vde;                            // latched per line
    end
  end

  assign ade = ade_ff & timing.ahde;

endmodule

// ==== crt_top.sv ====
module crt_top #(
  parameter int DOTS_MAX = 9
) (
  input  logic               t_crt_clk,
  input  logic               h_reset_n,
  input  logic               io_wr,
  input  logic               io_rd,
  input  crt_pkg::crt_port_t io_port,
  input  logic [7:0]         io_wdata,
  input  logic               vga_en,
  output logic               crt_int,
  output logic               attr_de,
  output logic               cblank_n,
  output logic               ade,
  output logic               screen_off,
  output logic               dis_en_sta,
  output logic               hsync,
  output logic               vsync
);
  import crt_pkg::*;

  crt_regs_t   crt_regs;
  seq_regs_t   seq_regs;
  logic        attr_pas;
  crt_timing_t timing;

  // ******************************
  // decode, timing, output stage
  // ******************************
  crt_reg_decode reg_decode_i (
    .t_crt_clk (t_crt_clk),
    .h_reset_n (h_reset_n),
    .io_wr     (io_wr),
    .io_rd     (io_rd),
    .io_port   (io_port),
    .io_wdata  (io_wdata),
    .crt_regs  (crt_regs),
    .seq_regs  (seq_regs),
    .attr_pas  (attr_pas)
  );

  crt_timing_gen #(
    .DOTS_MAX (DOTS_MAX)
  ) timing_gen_i (
    .t_crt_clk (t_crt_clk),
    .h_reset_n (h_reset_n),
    .crt_regs  (crt_regs),
    .sr01_b0   (seq_regs.sr01[0]),
    .timing    (timing)
  );

  crt_op_stage op_stage_i (
    .t_crt_clk  (t_crt_clk),
    .h_reset_n  (h_reset_n),
    .timing     (timing),
    .cr11       (crt_regs.cr11),
    .sr01_b5    (seq_regs.sr01[5]),
    .attr_pas   (attr_pas),
    .vga_en     (vga_en),
    .crt_int    (crt_int),
    .attr_de    (attr_de),
    .cblank_n   (cblank_n),
    .ade        (ade),
    .screen_off (screen_off),
    .dis_en_sta (dis_en_sta)
  );

  assign hsync = timing.hsync;   // sync leaves without the output stage delay
  assign vsync = timing.vsync;

endmodule

// ==== crt_checker.sv ====
module crt_checker (
  input  logic t_crt_clk,
  input  logic io_wr,
  input  logic io_rd,
  input  logic vga_en,
  input  logic vsync,
  input  logic hsync,
  input  logic attr_de,
  input  logic cblank_n,
  input  logic ade,
  input  logic dis_en_sta,
  input  logic crt_int,
  input  logic screen_off,
  input  logic start,
  input  int   exp_len,
  input  int   exp_attr,
  input  int   exp_blank,
  input  logic exp_int,
  input  int   exp_dis,
  input  int   exp_hs,
  output logic done,
  output int   err_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    CHK_IDLE,
    CHK_SEEK,
    CHK_SKIP,
    CHK_COUNT
  } chk_state_t;

  chk_state_t state;
  logic       vsync_q;
  logic       vga_en_q;
  logic       dirty;          // io access or vga_en change since the last skipped frame
  logic       vs_rise;
  int         n_clk;
  int         n_attr;
  int         n_blank;
  int         n_dis;
  int         n_ade;
  int         n_hs;

  assign vs_rise = vsync & ~vsync_q;   // frame boundary

  task automatic compare_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic clear_counts();
    n_clk   = 0;
    n_attr  = 0;
    n_blank = 0;
    n_dis   = 0;
    n_ade   = 0;
    n_hs    = 0;
  endtask

  initial begin
    state    = CHK_IDLE;
    vsync_q  = 1'b0;
    vga_en_q = 1'b1;
    dirty    = 1'b1;
    done     = 1'b0;
    err_cnt  = 0;
    clear_counts();
  end

  // ******************************
  // frame counting
  // ******************************
  always @(posedge t_crt_clk) begin
    vsync_q  <= vsync;
    vga_en_q <= vga_en;
    done     <= 1'b0;
    case (state)
      CHK_IDLE: begin
        if (start) state <= CHK_SEEK;
      end
      CHK_SEEK: begin
        if (vs_rise) begin
          state <= dirty ? CHK_SKIP : CHK_COUNT;   // first frame after a write is dropped
          dirty <= 1'b0;
          clear_counts();
        end
      end
      CHK_SKIP: begin
        if (vs_rise) begin
          state <= CHK_COUNT;
          clear_counts();
        end
      end
      CHK_COUNT: begin
        n_clk++;
        if (attr_de) n_attr++;
        if (!cblank_n) n_blank++;
        if (!dis_en_sta) n_dis++;
        if (ade) n_ade++;
        if (hsync) n_hs++;
        if (vs_rise) begin
          compare_count("frame clocks", n_clk, exp_len);
          compare_count("attr_de high clocks", n_attr, exp_attr);
          compare_count("cblank_n low clocks", n_blank, exp_blank);
          compare_count("dis_en_sta low clocks", n_dis, exp_dis);
          // ade spans the same display area, one char ahead
          compare_count("ade high clocks", n_ade, exp_dis);
          compare_count("hsync high clocks", n_hs, exp_hs);
          compare_count("crt_int at frame end", int'(crt_int), int'(exp_int));
          // a fully blanked frame means the screen is off
          compare_count("screen_off", int'(screen_off), int'(exp_blank == exp_len));
          done  <= 1'b1;
          state <= CHK_IDLE;
        end
      end
      default: state <= CHK_IDLE;
    endcase
    if (io_wr || io_rd || (vga_en !== vga_en_q)) dirty <= 1'b1;
  end

endmodule

// ==== tb_crt_top.sv ====
module tb_crt_top;
  timeunit 1ns;
  timeprecision 100ps;
  import crt_pkg::*;

  localparam int    DOTS_MAX = 9;
  localparam string VEC_FILE = "crt_vectors.txt";

  typedef struct packed {
    logic [7:0] kind;         // w, r or f
    logic [2:0] port;
    logic [7:0] data;
    logic       vga;
    int         len;          // frame length in clocks
    int         attr;
    int         blank;
    logic       intr;
    int         dis;
    int         hs;           // hsync clocks per frame
  } vec_rec_t;

  logic       t_crt_clk;
  logic       h_reset_n;
  logic       io_wr;
  logic       io_rd;
  crt_port_t  io_port;
  logic [7:0] io_wdata;
  logic       vga_en;
  logic       crt_int;
  logic       attr_de;
  logic       cblank_n;
  logic       ade;
  logic       screen_off;
  logic       dis_en_sta;
  logic       hsync;
  logic       vsync;

  logic       start;
  int         exp_len;
  int         exp_attr;
  int         exp_blank;
  logic       exp_int;
  int         exp_dis;
  int         exp_hs;
  logic       done;
  int         chk_err;

  vec_rec_t   recs[$];
  int         fmt_err;
  int         rec_idx;
  int         cycle_cnt;
  int         cycle_limit;

  crt_top #(
    .DOTS_MAX (DOTS_MAX)
  ) dut_i (
    .t_crt_clk  (t_crt_clk),
    .h_reset_n  (h_reset_n),
    .io_wr      (io_wr),
    .io_rd      (io_rd),
    .io_port    (io_port),
    .io_wdata   (io_wdata),
    .vga_en     (vga_en),
    .crt_int    (crt_int),
    .attr_de    (attr_de),
    .cblank_n   (cblank_n),
    .ade        (ade),
    .screen_off (screen_off),
    .dis_en_sta (dis_en_sta),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  crt_checker chk_i (
    .t_crt_clk  (t_crt_clk),
    .io_wr      (io_wr),
    .io_rd      (io_rd),
    .vga_en     (vga_en),
    .vsync      (vsync),
    .hsync      (hsync),
    .attr_de    (attr_de),
    .cblank_n   (cblank_n),
    .ade        (ade),
    .dis_en_sta (dis_en_sta),
    .crt_int    (crt_int),
    .screen_off (screen_off),
    .start      (start),
    .exp_len    (exp_len),
    .exp_attr   (exp_attr),
    .exp_blank  (exp_blank),
    .exp_int    (exp_int),
    .exp_dis    (exp_dis),
    .exp_hs     (exp_hs),
    .done       (done),
    .err_cnt    (chk_err)
  );

  initial begin
    t_crt_clk = 1'b0;
    forever #20 t_crt_clk = ~t_crt_clk;
  end

  // ******************************
  // vector file
  // ******************************
  task automatic load_vectors();
    int       fd;
    int       line_no;
    int       p;
    int       d;
    int       v;
    int       a;
    int       b;
    int       i;
    int       s;
    int       crtc_idx;
    int       seq_idx;
    int       h_total;
    int       v_total;
    int       h_sync_start;
    int       h_sync_end;
    int       dots;
    int       frames;
    int       limit;
    string    line;
    string    tok;
    vec_rec_t rec;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the vector file %s", VEC_FILE);
      fmt_err++;
      return;
    end
    line_no      = 0;
    crtc_idx     = 0;
    seq_idx      = 0;
    h_total      = 0;
    v_total      = 0;
    h_sync_start = 0;
    h_sync_end   = 0;
    dots         = DOTS_MAX;
    frames       = 0;
    limit        = 0;
    while ($fgets(line, fd) > 0) begin
      line_no++;
      rec = '0;
      if ($sscanf(line, "%s", tok) != 1 || tok[0] == "#") continue;
      if (tok == "w" && $sscanf(line, "%s %d %h", tok, p, d) == 3 && p <= 4) begin
        rec.kind = "w";
        rec.port = p;
        rec.data = d;
        case (p)   // shadow copy for the frame length
          0: crtc_idx = d;
          1: begin
            if (crtc_idx == CR_H_TOTAL) h_total = d;
            if (crtc_idx == CR_V_TOTAL) v_total = d;
            if (crtc_idx == CR_H_SYNC_START) h_sync_start = d;
            if (crtc_idx == CR_H_SYNC_END) h_sync_end = d;
          end
          2: seq_idx = d;
          3: if (seq_idx == SR_CLK_MODE) dots = d[0] ? 8 : DOTS_MAX;
          default: ;
        endcase
        limit += 5;
      end else if (tok == "r" && $sscanf(line, "%s %d", tok, p) == 2 && p == 5) begin
        rec.kind = "r";
        rec.port = p;
        limit += 5;
      end else if (tok == "f" && $sscanf(line, "%s %d %d %d %d %d", tok, v, a, b, i, s) == 6) begin
        rec.kind  = "f";
        rec.vga   = v[0];
        rec.len   = (h_total + 1) * (v_total + 1) * dots;
        rec.attr  = a;
        rec.blank = b;
        rec.intr  = i[0];
        rec.dis   = s;
        rec.hs    = (h_sync_end - h_sync_start + 1) * (v_total + 1) * dots;
        limit += 3 * rec.len;       // partial, skipped and counted frame
        frames++;
      end else begin
        $display("vector file line %0d is not a valid record", line_no);
        fmt_err++;
        continue;
      end
      recs.push_back(rec);
    end
    $fclose(fd);
    if (frames == 0) begin
      $display("vector file holds no frame record");
      fmt_err++;
    end
    cycle_limit = limit + limit / 5 + 20;
  endtask

  task automatic drive_write(input logic [2:0] port, input logic [7:0] data);
    repeat ($urandom_range(3, 0)) @(posedge t_crt_clk);
    @(posedge t_crt_clk);
    io_wr    <= 1'b1;
    io_port  <= crt_port_t'(port);
    io_wdata <= data;
    @(posedge t_crt_clk);
    io_wr <= 1'b0;
  endtask

  task automatic drive_read(input logic [2:0] port);
    repeat ($urandom_range(3, 0)) @(posedge t_crt_clk);
    @(posedge t_crt_clk);
    io_rd   <= 1'b1;
    io_port <= crt_port_t'(port);
    @(posedge t_crt_clk);
    io_rd <= 1'b0;
  endtask

  task automatic run_frame(input vec_rec_t rec);
    @(posedge t_crt_clk);
    vga_en    <= rec.vga;
    exp_len   <= rec.len;
    exp_attr  <= rec.attr;
    exp_blank <= rec.blank;
    exp_int   <= rec.intr;
    exp_dis   <= rec.dis;
    exp_hs    <= rec.hs;
    start     <= 1'b1;
    @(posedge t_crt_clk);
    start <= 1'b0;
    while (!done) @(posedge t_crt_clk);
  endtask

  task automatic finish_run(input logic timed_out);
    int total;
    total = chk_err + fmt_err + int'(timed_out);
    $display("errors: %0d value, %0d format, %0d timeout", chk_err, fmt_err, int'(timed_out));
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // ******************************
  // stimulus
  // ******************************
  initial begin
    h_reset_n   = 1'b0;
    io_wr       = 1'b0;
    io_rd       = 1'b0;
    io_port     = PORT_CRTC_IDX;
    io_wdata    = 8'h00;
    vga_en      = 1'b1;
    start       = 1'b0;
    exp_len     = 0;
    exp_attr    = 0;
    exp_blank   = 0;
    exp_int     = 1'b0;
    exp_dis     = 0;
    exp_hs      = 0;
    fmt_err     = 0;
    rec_idx     = 0;
    cycle_limit = 0;
    void'($urandom(56049));
    load_vectors();
    repeat (5) @(posedge t_crt_clk);
    h_reset_n <= 1'b1;
    if (fmt_err == 0) begin
      foreach (recs[k]) begin
        rec_idx = k;
        case (recs[k].kind)
          "w":     drive_write(recs[k].port, recs[k].data);
          "r":     drive_read(recs[k].port);
          default: run_frame(recs[k]);
        endcase
      end
    end
    repeat (4) @(posedge t_crt_clk);
    finish_run(1'b0);
  end

  initial cycle_cnt = 0;

  always @(posedge t_crt_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, vector record %0d never finished its frame",
               cycle_cnt, rec_idx);
      finish_run(1'b1);
    end
  end

endmodule

// ==== crt_vectors.txt ====
# w <port> <byte hex>: write; port 0 crtc index, 1 crtc data, 2 seq index, 3 seq data, 4 attr
# r <port>: read strobe, port 5 is the status port
# f <vga_en> <attr_de clocks> <cblank_n low clocks> <crt_int at frame end> <dis_en_sta low clocks>
# 12 x 10 characters, display 8 x 6, 9 dot characters
w 2 01
w 3 00
w 0 00
w 1 0b
w 0 01
w 1 07
w 0 02
w 1 08
w 0 03
w 1 0b
w 0 04
w 1 09
w 0 05
w 1 0a
w 0 06
w 1 09
w 0 12
w 1 05
w 0 15
w 1 06
w 0 16
w 1 09
w 0 10
w 1 07
w 0 11
w 1 18
w 4 20
w 4 00
f 1 432 648 1 432
# 8 dot characters
w 3 01
f 1 384 576 1 384
# pas clear, status read back to index state
w 4 00
r 5
f 1 0 576 1 384
# three attr writes leave data state, the status read restores index state
w 4 00
w 4 20
w 4 05
r 5
w 4 20
f 1 384 576 1 384
# screen off
w 3 21
f 1 384 960 1 384
# screen on again but vga_en low
w 3 01
f 0 384 960 1 384
# interrupt clear, then set again
w 0 11
w 1 08
f 1 384 576 0 384
w 1 18
f 1 384 576 1 384
# back to 9 dot characters
w 3 00
f 1 432 648 1 432

// ==== files.f ====
crt_pkg.sv
crt_reg_decode.sv
crt_timing_gen.sv
crt_op_stage.sv
crt_top.sv
crt_checker.sv
tb_crt_top.sv
